/* pipeline_pkg.sv */
package pipeline_pkg;

    localparam int NB_DATA    = 32;
    localparam int NB_REG     = 5;
    localparam int NB_IM_ADDR = 6;
    localparam int NB_OPCODE  = 6;
    localparam int IM_DEPTH   = 2**NB_IM_ADDR;
    localparam int REG_COUNT  = 2**NB_REG;

    typedef logic [NB_DATA-1:0]    data_t;
    typedef logic [NB_REG-1:0]     reg_idx_t;
    typedef logic [NB_DATA-1:0]    pc_t;        // Byte address
    typedef logic [NB_IM_ADDR-1:0] im_addr_t;   // Word index

    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'd0;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'd8;
    localparam logic [NB_OPCODE-1:0] OP_HALT  = 6'd63;

    localparam logic [NB_OPCODE-1:0] FN_ADD = 6'd32;
    localparam logic [NB_OPCODE-1:0] FN_SUB = 6'd34;
    localparam logic [NB_OPCODE-1:0] FN_AND = 6'd36;
    localparam logic [NB_OPCODE-1:0] FN_OR  = 6'd37;
    localparam logic [NB_OPCODE-1:0] FN_SLT = 6'd42;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,    // Value read in decode
        FWD_MEM,    // EX/MEM result
        FWD_WB      // MEM/WB result
    } fwd_sel_e;

endpackage

/* pipeline_if.sv */
`timescale 1ns/1ps

interface exec_if import pipeline_pkg::*; ();
    alu_op_e  alu_op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    data_t    data_a;
    data_t    data_b;
    data_t    imm;          // Already sign extended
    logic     use_imm;
    logic     reg_write;

    modport source (output alu_op, rs, rt, dest, data_a, data_b, imm, use_imm, reg_write);
    modport sink   (input  alu_op, rs, rt, dest, data_a, data_b, imm, use_imm, reg_write);
    modport monitor (input rs, rt);
endinterface

interface result_if import pipeline_pkg::*; ();
    logic     reg_write;    // Low for a bubble
    reg_idx_t dest;
    data_t    result;
    logic     halt;

    modport source  (output reg_write, dest, result, halt);
    modport sink    (input  reg_write, dest, result, halt);
    modport monitor (input  reg_write, dest, result);
endinterface

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import pipeline_pkg::*; (
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_pc_enable,
    input  logic     i_im_write_enable,
    input  im_addr_t i_im_address,
    input  data_t    i_im_data,
    output pc_t      o_pc,
    output data_t    o_inst,
    output logic     o_halt
);
    data_t imem [IM_DEPTH];
    pc_t   pc;
    logic  halted;
    data_t inst;
    logic  is_halt;
    logic  fetch_en;

    assign inst     = imem[pc[NB_IM_ADDR+1:2]];    // Word aligned read
    assign is_halt  = inst[31:26] == OP_HALT;
    assign fetch_en = i_pc_enable && !halted;
    assign o_pc     = pc;

    always_ff @(posedge i_clock) begin
        if (i_im_write_enable) begin
            imem[i_im_address] <= i_im_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc     <= '0;
            halted <= 1'b0;
            o_inst <= '0;
            o_halt <= 1'b0;
        end else begin
            if (fetch_en) begin
                pc     <= pc + 32'd4;
                halted <= is_halt;     // Freezes at halt address plus 4
            end
            o_inst <= fetch_en ? inst : '0;    // Zero word decodes as bubble
            o_halt <= fetch_en && is_halt;
        end
    end

    a_pc_frozen: assert property (@(posedge i_clock) (halted && !i_rst) |=> $stable(pc));

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file import pipeline_pkg::*; (
    input  logic     i_clock,
    input  logic     i_rst,
    input  reg_idx_t i_rs,
    input  reg_idx_t i_rt,
    input  reg_idx_t i_rb_address,
    result_if.sink   wb,
    output data_t    o_data_a,
    output data_t    o_data_b,
    output data_t    o_rb_data
);
    data_t regs [REG_COUNT];

    // Same-cycle write is visible to decode
    function automatic data_t read_port(input reg_idx_t idx);
        data_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.reg_write && wb.dest == idx) begin
            value = wb.result;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign o_data_a  = read_port(i_rs);
    assign o_data_b  = read_port(i_rt);
    assign o_rb_data = regs[i_rb_address];    // Debug read

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.dest] <= wb.result;
        end
    end

    a_no_r0_write: assert property (@(posedge i_clock) disable iff (i_rst)
        wb.reg_write |-> wb.dest != '0);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import pipeline_pkg::*; (
    input  logic     i_clock,
    input  logic     i_rst,
    input  data_t    i_inst,
    input  logic     i_halt,
    input  reg_idx_t i_rb_address,
    result_if.sink   wb,
    exec_if.source   ex,
    output data_t    o_rb_data,
    output logic     o_halt
);
    logic [NB_OPCODE-1:0] opcode;
    logic [NB_OPCODE-1:0] funct;
    reg_idx_t             rs;
    reg_idx_t             rt;
    reg_idx_t             rd;
    reg_idx_t             dest;
    data_t                imm;
    data_t                data_a;
    data_t                data_b;
    alu_op_e              alu_op;
    logic                 use_imm;
    logic                 valid;

    assign opcode = i_inst[31:26];
    assign rs     = i_inst[25:21];
    assign rt     = i_inst[20:16];
    assign rd     = i_inst[15:11];
    assign funct  = i_inst[5:0];
    assign imm    = {{16{i_inst[15]}}, i_inst[15:0]};

    register_file register_file_1 (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_rs         (rs),
        .i_rt         (rt),
        .i_rb_address (i_rb_address),
        .wb           (wb),
        .o_data_a     (data_a),
        .o_data_b     (data_b),
        .o_rb_data    (o_rb_data)
    );

    always_comb begin
        alu_op  = ALU_NOP;
        use_imm = 1'b0;
        valid   = 1'b0;
        dest    = rd;
        case (opcode)
            OP_RTYPE: begin
                valid = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: valid = 1'b0;    // Includes the all-zero word
                endcase
            end
            OP_ADDI: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                valid   = 1'b1;
                dest    = rt;
            end
            default: ;    // Halt and unknown codes go down as bubbles
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            ex.alu_op    <= ALU_NOP;
            ex.use_imm   <= 1'b0;
            ex.reg_write <= 1'b0;
            o_halt       <= 1'b0;
        end else begin
            ex.alu_op    <= alu_op;
            ex.use_imm   <= use_imm;
            ex.reg_write <= valid && dest != '0;    // r0 stays zero
            o_halt       <= i_halt;
        end
    end

    always_ff @(posedge i_clock) begin
        ex.rs     <= rs;
        ex.rt     <= rt;
        ex.dest   <= dest;
        ex.data_a <= data_a;
        ex.data_b <= data_b;
        ex.imm    <= imm;
    end

endmodule

/* forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit import pipeline_pkg::*; (
    exec_if.monitor   ex,
    result_if.monitor em,
    result_if.monitor wb,
    output fwd_sel_e  o_fwd_a,
    output fwd_sel_e  o_fwd_b
);
    // Newer result wins
    function automatic fwd_sel_e pick_source(input reg_idx_t src);
        fwd_sel_e sel;
        if (src == '0) begin
            sel = FWD_REG;
        end else if (em.reg_write && em.dest == src) begin
            sel = FWD_MEM;
        end else if (wb.reg_write && wb.dest == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(ex.rs);
        o_fwd_b = pick_source(ex.rt);
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import pipeline_pkg::*; (
    input  logic      i_clock,
    input  logic      i_rst,
    input  logic      i_halt,
    input  fwd_sel_e  i_fwd_a,
    input  fwd_sel_e  i_fwd_b,
    exec_if.sink      ex,
    result_if.monitor wb_fwd,
    result_if.source  em,
    output logic      o_oe
);
    data_t op_a;
    data_t reg_b;
    data_t op_b;
    data_t alu_res;
    logic  ovf;

    function automatic data_t forward(input fwd_sel_e sel, input data_t reg_val);
        data_t value;
        case (sel)
            FWD_MEM: value = em.result;
            FWD_WB:  value = wb_fwd.result;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    always_comb begin
        op_a  = forward(i_fwd_a, ex.data_a);
        reg_b = forward(i_fwd_b, ex.data_b);
        op_b  = ex.use_imm ? ex.imm : reg_b;    // addi
    end

    always_comb begin
        alu_res = '0;
        ovf     = 1'b0;
        case (ex.alu_op)
            ALU_ADD: begin
                alu_res = op_a + op_b;
                ovf = (op_a[NB_DATA-1] == op_b[NB_DATA-1]) &&
                      (alu_res[NB_DATA-1] != op_a[NB_DATA-1]);
            end
            ALU_SUB: begin
                alu_res = op_a - op_b;
                ovf = (op_a[NB_DATA-1] != op_b[NB_DATA-1]) &&
                      (alu_res[NB_DATA-1] != op_a[NB_DATA-1]);
            end
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {{(NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            em.reg_write <= 1'b0;
            em.halt      <= 1'b0;
            o_oe         <= 1'b0;
        end else begin
            em.reg_write <= ex.reg_write && !ovf;    // Overflow drops the write
            em.halt      <= i_halt;
            if (ovf) begin
                o_oe <= 1'b1;    // Sticky until reset
            end
        end
    end

    always_ff @(posedge i_clock) begin
        em.dest   <= ex.dest;
        em.result <= alu_res;
    end

    a_nop_no_write: assert property (@(posedge i_clock) disable iff (i_rst)
        ex.alu_op == ALU_NOP |-> !ex.reg_write);

endmodule

/* retire_stage.sv */
`timescale 1ns/1ps

module retire_stage import pipeline_pkg::*; (
    input  logic     i_clock,
    input  logic     i_rst,
    result_if.sink   em,
    result_if.source wb,
    output logic     o_hlt
);

    // Memory slot has no work left, only the MEM/WB register
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            wb.reg_write <= 1'b0;
            wb.halt      <= 1'b0;
            o_hlt        <= 1'b0;
        end else begin
            wb.reg_write <= em.reg_write;
            wb.halt      <= em.halt;
            if (em.halt) begin
                o_hlt <= 1'b1;    // Held until reset
            end
        end
    end

    always_ff @(posedge i_clock) begin
        wb.dest   <= em.dest;
        wb.result <= em.result;
    end

endmodule

/* mips_top.sv */
`timescale 1ns/1ps

module mips_top import pipeline_pkg::*; (
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_pc_enable,
    input  logic     i_im_write_enable,
    input  im_addr_t i_im_address,
    input  data_t    i_im_data,
    input  reg_idx_t i_rb_address,
    output pc_t      o_pc_value,
    output data_t    o_rb_data,
    output logic     o_hlt,
    output logic     o_oe
);
    data_t    id_inst;
    logic     id_halt;
    logic     ex_halt;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    exec_if   ex_bus ();
    result_if em_bus ();    // EX/MEM
    result_if wb_bus ();    // MEM/WB, also the register write bus

    fetch_stage fetch_stage_1 (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_pc_enable       (i_pc_enable),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_pc              (o_pc_value),
        .o_inst            (id_inst),
        .o_halt            (id_halt)
    );

    decode_stage decode_stage_1 (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_inst       (id_inst),
        .i_halt       (id_halt),
        .i_rb_address (i_rb_address),
        .wb           (wb_bus.sink),
        .ex           (ex_bus.source),
        .o_rb_data    (o_rb_data),
        .o_halt       (ex_halt)
    );

    forwarding_unit forwarding_unit_1 (
        .ex      (ex_bus.monitor),
        .em      (em_bus.monitor),
        .wb      (wb_bus.monitor),
        .o_fwd_a (fwd_a),
        .o_fwd_b (fwd_b)
    );

    execute_stage execute_stage_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_halt  (ex_halt),
        .i_fwd_a (fwd_a),
        .i_fwd_b (fwd_b),
        .ex      (ex_bus.sink),
        .wb_fwd  (wb_bus.monitor),
        .em      (em_bus.source),
        .o_oe    (o_oe)
    );

    retire_stage retire_stage_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .em      (em_bus.sink),
        .wb      (wb_bus.source),
        .o_hlt   (o_hlt)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clock
);
    localparam int HALF_PERIOD = 10;    // 20 ns period

    initial begin
        o_clock = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clock = ~o_clock;
        end
    end

endmodule

/* tb_mips_top.sv */
`timescale 1ns/1ps

module tb_mips_top import pipeline_pkg::*; ();
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 10;
    localparam int NUM_TESTS    = 5;
    // Writes, reset, longest program, halt hold, register reads, slack
    localparam int MAX_CYCLES   = NUM_TESTS * (IM_DEPTH + RESET_CYCLES + IM_DEPTH
                                  + HOLD_CYCLES + REG_COUNT + 10) + RESET_CYCLES;

    logic     clock;
    logic     rst;
    logic     pc_enable;
    logic     im_write_enable;
    im_addr_t im_address;
    data_t    im_data;
    reg_idx_t rb_address;
    pc_t      pc_value;
    data_t    rb_data;
    logic     hlt;
    logic     oe;

    data_t prog [IM_DEPTH];
    int    prog_len;
    int    seed = 38;
    int    cycle_count = 0;
    int    test_errors;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    total_errors = 0;

    tb_clock_gen clock_gen_1 (.o_clock(clock));

    mips_top i_dut (
        .i_clock           (clock),
        .i_rst             (rst),
        .i_pc_enable       (pc_enable),
        .i_im_write_enable (im_write_enable),
        .i_im_address      (im_address),
        .i_im_data         (im_data),
        .i_rb_address      (rb_address),
        .o_pc_value        (pc_value),
        .o_rb_data         (rb_data),
        .o_hlt             (hlt),
        .o_oe              (oe)
    );

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic data_t r_type(input logic [NB_OPCODE-1:0] fn, input int rd, rs, rt);
        return {OP_RTYPE, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), 5'd0, fn};
    endfunction

    function automatic data_t addi_word(input int rt, rs, imm);
        return {OP_ADDI, reg_idx_t'(rs), reg_idx_t'(rt), 16'(imm)};
    endfunction

    function automatic data_t halt_word();
        return {OP_HALT, 26'd0};
    endfunction

    function automatic int rand_reg();
        return 1 + ($random(seed) & 15);
    endfunction

    // Sequential execution of the program up to the first halt
    function automatic logic run_reference(output data_t regs [REG_COUNT]);
        data_t                w;
        data_t                a;
        data_t                b;
        data_t                res;
        longint               wide;
        logic [NB_OPCODE-1:0] op;
        reg_idx_t             dest;
        logic                 writes;
        logic                 ovf;
        logic                 any_ovf;
        any_ovf = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) begin
            regs[r] = '0;
        end
        for (int p = 0; p < IM_DEPTH; p++) begin
            w = prog[p];
            op = w[31:26];
            if (op == OP_HALT) begin
                break;
            end
            a = regs[w[25:21]];
            b = (op == OP_ADDI) ? {{16{w[15]}}, w[15:0]} : regs[w[20:16]];
            dest = (op == OP_ADDI) ? w[20:16] : w[15:11];
            writes = (op == OP_ADDI) || (op == OP_RTYPE);
            wide = 0;
            res = '0;
            ovf = 1'b0;
            if (op == OP_ADDI || (op == OP_RTYPE && w[5:0] == FN_ADD)) begin
                wide = longint'($signed(a)) + longint'($signed(b));
            end else if (op == OP_RTYPE && w[5:0] == FN_SUB) begin
                wide = longint'($signed(a)) - longint'($signed(b));
            end else if (op == OP_RTYPE && w[5:0] == FN_AND) begin
                wide = longint'(a & b);
            end else if (op == OP_RTYPE && w[5:0] == FN_OR) begin
                wide = longint'(a | b);
            end else if (op == OP_RTYPE && w[5:0] == FN_SLT) begin
                wide = ($signed(a) < $signed(b)) ? 1 : 0;
            end else begin
                writes = 1'b0;    // Zero word and unknown codes
            end
            res = data_t'(wide);
            if (writes && (w[5:0] == FN_ADD || w[5:0] == FN_SUB || op == OP_ADDI)) begin
                ovf = wide != longint'($signed(res));    // Result needs more than 32 bits
            end
            if (ovf) begin
                any_ovf = 1'b1;
            end else if (writes && dest != 0) begin
                regs[dest] = res;
            end
        end
        return any_ovf;
    endfunction

    task automatic clear_program();
        for (int p = 0; p < IM_DEPTH; p++) begin
            prog[p] = '0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input data_t w);
        if (prog_len < IM_DEPTH) begin
            prog[prog_len] = w;
            prog_len++;
        end
    endtask

    task automatic emit_bubbles(input int n);
        repeat (n) emit('0);
    endtask

    task automatic build_independent();
        logic [NB_OPCODE-1:0] fns [5];
        fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
        clear_program();
        for (int k = 0; k < 6; k++) begin
            emit(addi_word(rand_reg(), 0, $random(seed)));
        end
        for (int k = 0; k < 5; k++) begin
            emit_bubbles(3);    // Far enough apart that no forwarding is needed
            emit(r_type(fns[k], 17 + k, rand_reg(), rand_reg()));
        end
        emit(halt_word());
    endtask

    task automatic build_forwarding();
        clear_program();
        emit(addi_word(1, 0, 5));
        emit(addi_word(2, 1, 7));
        emit(r_type(FN_ADD, 3, 1, 2));
        emit(r_type(FN_ADD, 4, 3, 1));
        emit(r_type(FN_OR, 5, 2, 4));
        emit(r_type(FN_AND, 6, 4, 5));
        emit(r_type(FN_SUB, 7, 6, 5));
        emit(r_type(FN_ADD, 7, 7, 7));
        emit(addi_word(8, 7, -3));
        emit(r_type(FN_SLT, 9, 8, 7));
        emit(r_type(FN_ADD, 10, 9, 8));
        emit(r_type(FN_ADD, 11, 10, 10));
        emit(addi_word(12, 0, 1));
        emit(addi_word(12, 0, 2));
        emit(r_type(FN_ADD, 13, 12, 12));    // Newer write of r12 must win
        emit(halt_word());
    endtask

    task automatic build_zero_reg();
        clear_program();
        emit(addi_word(0, 0, 100));
        emit(r_type(FN_ADD, 1, 0, 0));
        emit(addi_word(2, 0, -7));
        emit(r_type(FN_OR, 0, 2, 2));
        emit(r_type(FN_SUB, 3, 0, 2));
        emit(addi_word(4, 0, 0));
        emit(r_type(FN_SLT, 5, 2, 0));
        emit(halt_word());
    endtask

    task automatic build_overflow();
        clear_program();
        emit(addi_word(2, 0, 9));
        emit(addi_word(1, 0, 16'h4000));
        repeat (16) emit(r_type(FN_ADD, 1, 1, 1));    // r1 = 2**30
        emit(r_type(FN_ADD, 2, 1, 1));
        emit(r_type(FN_ADD, 3, 2, 0));
        emit(r_type(FN_SLT, 4, 1, 0));
        emit(r_type(FN_SUB, 7, 0, 1));
        emit(r_type(FN_SUB, 8, 7, 1));    // Lands exactly on the most negative value
        emit(addi_word(9, 0, 5));
        emit(r_type(FN_SUB, 9, 8, 1));
        emit(halt_word());
    endtask

    task automatic build_halt();
        clear_program();
        emit(addi_word(1, 0, 11));
        emit(addi_word(2, 0, 22));
        emit(r_type(FN_ADD, 3, 1, 2));
        emit(halt_word());
        emit(addi_word(4, 0, 99));
        emit(r_type(FN_ADD, 1, 1, 1));
        emit(addi_word(5, 0, -1));
        emit(halt_word());
    endtask

    task automatic load_program();
        for (int p = 0; p < IM_DEPTH; p++) begin
            @(negedge clock);
            im_write_enable = 1'b1;
            im_address = im_addr_t'(p);
            im_data = prog[p];
        end
        @(negedge clock);
        im_write_enable = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clock);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input data_t expected, input data_t actual);
        $display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
        test_errors++;
    endtask

    task automatic run_test(input string name);
        data_t exp_regs [REG_COUNT];
        logic  exp_oe;
        int    halt_idx;
        pc_t   exp_pc;
        test_errors = 0;
        exp_oe = run_reference(exp_regs);
        halt_idx = IM_DEPTH - 1;
        for (int p = IM_DEPTH - 1; p >= 0; p--) begin
            if (prog[p][31:26] == OP_HALT) begin
                halt_idx = p;
            end
        end
        exp_pc = pc_t'(halt_idx * 4 + 4);
        @(negedge clock);
        pc_enable = 1'b0;
        load_program();
        apply_reset();
        pc_enable = 1'b1;
        while (!hlt) @(negedge clock);
        for (int c = 0; c <= HOLD_CYCLES; c++) begin
            if (pc_value !== exp_pc) begin
                report_mismatch(name, $sformatf("pc after halt, cycle %0d", c), exp_pc, pc_value);
            end
            @(negedge clock);
        end
        if (oe !== exp_oe) begin
            report_mismatch(name, "o_oe", data_t'(exp_oe), data_t'(oe));
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            rb_address = reg_idx_t'(r);
            @(negedge clock);
            if (rb_data !== exp_regs[r]) begin
                report_mismatch(name, $sformatf("r%0d", r), exp_regs[r], rb_data);
            end
        end
        pc_enable = 1'b0;
        total_errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    initial begin
        rst = 1'b1;
        pc_enable = 1'b0;
        im_write_enable = 1'b0;
        im_address = '0;
        im_data = '0;
        rb_address = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        build_independent();
        run_test("independent");
        build_forwarding();
        run_test("forwarding");
        build_zero_reg();
        run_test("register_zero");
        build_overflow();
        run_test("overflow");
        build_halt();
        run_test("halt");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, tests_passed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
pipeline_pkg.sv
pipeline_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
forwarding_unit.sv
execute_stage.sv
retire_stage.sv
mips_top.sv
tb_clock_gen.sv
tb_mips_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_top -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mips_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
